//--- src/flash_emu_pkg.sv
// flash emulator shared definitions
// widths, timing constants, bus records and the serial log word
`default_nettype none

package flash_emu_pkg;

	////////////////////////////////////////////////////////////
	// widths and timing constants
	////////////////////////////////////////////////////////////

	// sdram logical port
	localparam int SD_ADDR_W = 32;
	localparam int SD_DATA_W = 16;
	localparam int SD_MASK_W = 2;

	// flash side of the log records
	localparam int LOG_ADDR_W = 24;
	localparam int LOG_LEN_W = 8;
	localparam int LOG_TAG_W = 32;
	localparam int LOG_WORD_W = 64;
	localparam int LOG_REMAIN_W = 4;

	// bytes leaving the serializer for each kind of word
	localparam logic [LOG_REMAIN_W-1:0] COMPACT_BYTES = 4'd4;
	localparam logic [LOG_REMAIN_W-1:0] VERBOSE_BYTES = 4'd8;
	localparam logic [LOG_REMAIN_W-1:0] MONITOR_BYTES = 4'd4;
	localparam logic [LOG_REMAIN_W-1:0] MAX_LOG_BYTES = 4'd8;

	// ascii tag in front of a verbose record
	localparam logic [LOG_TAG_W-1:0] LOG_TAG_READ = "READ";

	// per transaction byte index, and how many data bytes follow the command
	localparam int BYTE_IDX_W = 16;
	localparam int BYTES_FWD_MAX = 3;

	// reset sequencing
	localparam int SDRAM_RESET_CYCLES = 64;
	localparam int SDRAM_RESET_CNT_W = $clog2(SDRAM_RESET_CYCLES + 1);
	localparam int REBOOT_CNT_W = 8;

	// scope trigger
	localparam logic [LOG_ADDR_W-1:0] TRIGGER_ADDR = 24'h000010;
	localparam int TRIGGER_HOLD = 31;
	localparam int TRIGGER_CNT_W = $clog2(TRIGGER_HOLD + 1);

	////////////////////////////////////////////////////////////
	// records
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic enable;
		logic we;
		logic [SD_ADDR_W-1:0] addr;
		logic [SD_DATA_W-1:0] wr_data;
		logic [SD_MASK_W-1:0] wr_mask;
	} sd_req_t;

	// one byte seen on the spi bus, cmd marks the first after chip select
	typedef struct packed {
		logic strobe;
		logic cmd;
		logic [7:0] mosi;
		logic [7:0] miso;
	} spi_byte_t;

	typedef struct packed {
		logic strobe;
		logic [LOG_ADDR_W-1:0] addr;
		logic [LOG_LEN_W-1:0] len;
	} log_rec_t;

	typedef struct packed {
		logic strobe;
		logic [7:0] data;
	} uart_byte_t;

	typedef enum logic [1:0] {
		LOG_BYTES = 2'd0,
		LOG_COMPACT = 2'd1,
		LOG_VERBOSE = 2'd2,
		LOG_MONITOR = 2'd3
	} log_mode_e;

	// shift word, always drained from the top byte down
	typedef union packed {
		struct packed {
			logic [LOG_ADDR_W-1:0] addr;
			logic [LOG_LEN_W-1:0] len;
			logic [LOG_WORD_W-LOG_ADDR_W-LOG_LEN_W-1:0] pad;
		} compact;
		struct packed {
			logic [LOG_TAG_W-1:0] tag;
			logic [LOG_ADDR_W-1:0] addr;
			logic [LOG_LEN_W-1:0] len;
		} verbose;
	} log_word_u;

endpackage

`default_nettype wire

//--- src/reset_ctl.sv
// reset sequencing for the emulator
// sdram power-up countdown and board reboot request
`timescale 1ns/100ps
`default_nettype none

module reset_ctl
	import flash_emu_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic btn_reboot_i,
	input wire logic host_reboot_i,
	output logic sdram_reset_o,
	output logic user_programn_o
);

	logic [SDRAM_RESET_CNT_W-1:0] sdram_rst_cnt_q;
	logic [REBOOT_CNT_W-1:0] reboot_cnt_q;
	logic reboot_held;

	////////////////////////////////////////////////////////////
	// sdram power-up countdown
	////////////////////////////////////////////////////////////

	// loaded on reset, the controller stays in reset until it runs out
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sdram_rst_cnt_q <= SDRAM_RESET_CNT_W'(SDRAM_RESET_CYCLES);
		else if (sdram_rst_cnt_q != '0)
			sdram_rst_cnt_q <= sdram_rst_cnt_q - 1'b1;
	end

	assign sdram_reset_o = sdram_rst_cnt_q != '0;

	////////////////////////////////////////////////////////////
	// reboot request
	////////////////////////////////////////////////////////////

	// button must be held, any release starts the count over
	// saturates once the top bit is reached so a long hold keeps the request
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			reboot_cnt_q <= '0;
		else if (!btn_reboot_i)
			reboot_cnt_q <= '0;
		else if (!reboot_held)
			reboot_cnt_q <= reboot_cnt_q + 1'b1;
	end

	assign reboot_held = reboot_cnt_q[REBOOT_CNT_W-1];

	// programn is active low, host can request a reboot at any time
	assign user_programn_o = !(reboot_held || host_reboot_i);

	// sdram controller only sees one release, a rise would restart its init
	sdram_reset_once: assert property (@(posedge clk) disable iff (reset)
		!$rose(sdram_reset_o))
		else $error("sdram reset rose without a system reset");

endmodule

`default_nettype wire

//--- src/sdram_arbiter.sv
// sdram request port arbiter
// spi flash engine owns the port while critical, host parser otherwise
`timescale 1ns/100ps
`default_nettype none

module sdram_arbiter
	import flash_emu_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic spi_critical_i,
	input wire logic spi_refresh_inhibit_i,
	input wire sd_req_t spi_req_i,
	input wire sd_req_t host_req_i,
	input wire logic sd_ack_level_i,
	input wire logic sd_idle_i,
	input wire logic uart_tx_ready_i,
	output sd_req_t sd_req_o,
	output logic sd_refresh_inhibit_o,
	output logic spi_ack_o,
	output logic host_ack_o,
	output logic host_idle_o,
	output logic host_tx_ready_o
);

	logic ack_prev_q;
	logic ack_pulse;

	////////////////////////////////////////////////////////////
	// request select
	////////////////////////////////////////////////////////////

	// critical takes over every field of the port at once
	// no registering here, the controller samples the request itself
	assign sd_req_o = spi_critical_i ? spi_req_i : host_req_i;

	// refresh can only be held off inside a critical window
	assign sd_refresh_inhibit_o = spi_critical_i && spi_refresh_inhibit_i;

	////////////////////////////////////////////////////////////
	// acknowledge level to pulse
	////////////////////////////////////////////////////////////

	// controller holds ack high for a while
	// both requesters want one strobe per access
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ack_prev_q <= 1'b0;
		else
			ack_prev_q <= sd_ack_level_i;
	end

	// first cycle of the level only
	assign ack_pulse = sd_ack_level_i && !ack_prev_q;

	// spi engine always sees the pulse
	assign spi_ack_o = ack_pulse;

	// host side is blanked during critical windows
	// an ack there belongs to the spi access
	assign host_ack_o = ack_pulse && !spi_critical_i;
	assign host_idle_o = sd_idle_i && !spi_critical_i;

	// keep host replies off the serial stream while the spi log may need it
	assign host_tx_ready_o = uart_tx_ready_i && !spi_critical_i;

	// a held ack level must never look like two accesses
	ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
		ack_pulse |=> !ack_pulse)
		else $error("sdram ack pulse lasted more than one cycle");

endmodule

`default_nettype wire

//--- src/log_ctrl_regs.sv
// host control register for the emulator
// selects the log mode and what the leds show
`timescale 1ns/100ps
`default_nettype none

module log_ctrl_regs
	import flash_emu_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire uart_byte_t host_rx_i,
	input wire logic spi_cs_n_i,
	input wire logic spi_output_enable_i,
	input wire logic spi_critical_i,
	input wire logic sd_we_i,
	input wire logic [7:0] spi_errors_i,
	output log_mode_e log_mode_o,
	output logic [7:0] led_o
);

	logic [7:0] ctrl_q;
	logic [7:0] led_status;
	logic show_raw;

	////////////////////////////////////////////////////////////
	// control register
	////////////////////////////////////////////////////////////

	// every received host byte is a register write
	// zero after reset means raw byte logging with live leds
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ctrl_q <= '0;
		else if (host_rx_i.strobe)
			ctrl_q <= host_rx_i.data;
	end

	// bits 1:0 pick the log mode
	assign log_mode_o = log_mode_e'(ctrl_q[1:0]);

	// bit 7 freezes the leds on the written byte
	assign show_raw = ctrl_q[7];

	////////////////////////////////////////////////////////////
	// led status
	////////////////////////////////////////////////////////////

	// live view, msb first
	// upper error nibble, sdram write, critical, miso drive, chip selected
	assign led_status = {
		spi_errors_i[7:4],
		sd_we_i,
		spi_critical_i,
		spi_output_enable_i,
		!spi_cs_n_i
	};

	assign led_o = show_raw ? ctrl_q : led_status;

endmodule

`default_nettype wire

//--- src/spi_log_serializer.sv
// spi traffic logger for the host serial stream
// one byte per cycle from spi bytes, records and host replies, plus scope trigger
`timescale 1ns/100ps
`default_nettype none

module spi_log_serializer
	import flash_emu_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire log_mode_e log_mode_i,
	input wire spi_byte_t spi_byte_i,
	input wire log_rec_t spi_log_i,
	input wire uart_byte_t host_tx_i,
	output uart_byte_t uart_tx_o,
	output logic trigger_o
);

	// shift word and how many of its bytes are still to go
	log_word_u word_q;
	logic [LOG_REMAIN_W-1:0] remain_q;

	// bytes seen since the last command byte
	logic [BYTE_IDX_W-1:0] byte_idx_q;
	logic [BYTE_IDX_W-1:0] cur_idx;

	// registered serial output
	logic tx_strobe_q;
	logic [7:0] tx_data_q;
	logic tx_strobe_d;
	logic [7:0] tx_data_d;

	// trigger hold
	logic [TRIGGER_CNT_W-1:0] hold_cnt_q;
	logic trigger_q;

	// per cycle decisions
	logic rec_load;
	logic mon_load;
	logic word_load;
	logic draining;
	logic fwd_spi;
	logic shift_word;
	logic send_spi;
	logic send_host;

	////////////////////////////////////////////////////////////
	// source selection
	////////////////////////////////////////////////////////////

	// index of the byte on the bus right now, command byte is 0
	assign cur_idx = spi_byte_i.cmd ? '0 : byte_idx_q;

	// records only count in the two record modes
	assign rec_load = spi_log_i.strobe
		&& (log_mode_i == LOG_COMPACT || log_mode_i == LOG_VERBOSE);

	// monitor mode packs each spi byte into a word of its own
	assign mon_load = spi_byte_i.strobe && log_mode_i == LOG_MONITOR;
	assign word_load = rec_load || mon_load;
	assign draining = remain_q != '0;

	// raw mode keeps the command and the first few bytes behind it
	assign fwd_spi = spi_byte_i.strobe && log_mode_i == LOG_BYTES
		&& cur_idx <= BYTE_IDX_W'(BYTES_FWD_MAX);

	// a load wins the cycle, then the draining word, then spi bytes, host last
	// whatever loses is dropped, there is no queue
	always_comb
	begin
		shift_word = 1'b0;
		send_spi = 1'b0;
		send_host = 1'b0;
		if (word_load)
		begin
			// output is quiet in the load cycle
		end
		else if (draining)
			shift_word = 1'b1;
		else if (fwd_spi)
			send_spi = 1'b1;
		else if (host_tx_i.strobe)
			send_host = 1'b1;
	end

	assign tx_strobe_d = shift_word || send_spi || send_host;

	always_comb
	begin
		if (shift_word)
			tx_data_d = word_q[LOG_WORD_W-1 -: 8];
		else if (send_spi)
			tx_data_d = spi_byte_i.mosi;
		else
			tx_data_d = host_tx_i.data;
	end

	////////////////////////////////////////////////////////////
	// transaction byte index
	////////////////////////////////////////////////////////////

	// counts every byte, logged or not; sticks at the top for long bursts
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			byte_idx_q <= '0;
		else if (spi_byte_i.strobe && spi_byte_i.cmd)
			byte_idx_q <= BYTE_IDX_W'(1);
		else if (spi_byte_i.strobe && byte_idx_q != '1)
			byte_idx_q <= byte_idx_q + 1'b1;
	end

	////////////////////////////////////////////////////////////
	// shift word
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			remain_q <= '0;
		else if (rec_load && log_mode_i == LOG_VERBOSE)
			remain_q <= VERBOSE_BYTES;
		else if (rec_load)
			remain_q <= COMPACT_BYTES;
		else if (mon_load)
			remain_q <= MONITOR_BYTES;
		else if (draining)
			remain_q <= remain_q - 1'b1;
	end

	// the view used for loading decides the byte layout on the wire
	// monitor reuses the compact view: index and mosi in addr, miso in len
	always_ff @(posedge clk)
	begin
		if (rec_load && log_mode_i == LOG_VERBOSE)
			word_q.verbose <= '{tag: LOG_TAG_READ, addr: spi_log_i.addr, len: spi_log_i.len};
		else if (rec_load)
			word_q.compact <= '{addr: spi_log_i.addr, len: spi_log_i.len, pad: '0};
		else if (mon_load)
			word_q.compact <= '{addr: {cur_idx, spi_byte_i.mosi}, len: spi_byte_i.miso, pad: '0};
		else if (shift_word)
			word_q <= word_q << 8;
	end

	////////////////////////////////////////////////////////////
	// serial output
	////////////////////////////////////////////////////////////

	// ready from the serial side is not looked at, bursts are short
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			tx_strobe_q <= 1'b0;
		else
			tx_strobe_q <= tx_strobe_d;
	end

	always_ff @(posedge clk)
	begin
		if (tx_strobe_d)
			tx_data_q <= tx_data_d;
	end

	assign uart_tx_o = '{strobe: tx_strobe_q, data: tx_data_q};

	////////////////////////////////////////////////////////////
	// scope trigger
	////////////////////////////////////////////////////////////

	// any record restarts the hold, only the watched address raises it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			hold_cnt_q <= '0;
			trigger_q <= 1'b0;
		end
		else if (spi_log_i.strobe)
		begin
			hold_cnt_q <= TRIGGER_CNT_W'(TRIGGER_HOLD);
			if (spi_log_i.addr == TRIGGER_ADDR)
				trigger_q <= 1'b1;
		end
		else if (hold_cnt_q != '0)
			hold_cnt_q <= hold_cnt_q - 1'b1;
		else
			trigger_q <= 1'b0;
	end

	assign trigger_o = trigger_q;

	// longest word is a verbose record
	remain_in_range: assert property (@(posedge clk) disable iff (reset)
		remain_q <= MAX_LOG_BYTES)
		else $error("serializer byte count out of range");

endmodule

`default_nettype wire

//--- src/flash_emu_core.sv
// flash emulator glue between spi engine, sdram and host serial
// reset sequencing, sdram arbitration, control register and spi logging
`timescale 1ns/100ps
`default_nettype none

module flash_emu_core
	import flash_emu_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	// spi device and flash engine
	input wire spi_byte_t spi_byte_i,
	input wire log_rec_t spi_log_i,
	input wire logic spi_critical_i,
	input wire logic spi_refresh_inhibit_i,
	input wire logic spi_output_enable_i,
	input wire logic spi_cs_n_i,
	input wire logic [7:0] spi_errors_i,
	input wire sd_req_t spi_req_i,
	input wire sd_req_t host_req_i,
	// sdram controller
	input wire logic sd_ack_level_i,
	input wire logic sd_idle_i,
	// host serial and command parser
	input wire uart_byte_t host_rx_i,
	input wire uart_byte_t host_tx_i,
	input wire logic uart_tx_ready_i,
	// board
	input wire logic btn_reboot_i,
	input wire logic host_reboot_i,
	output sd_req_t sd_req_o,
	output logic sd_refresh_inhibit_o,
	output logic sdram_reset_o,
	output logic spi_ack_o,
	output logic host_ack_o,
	output logic host_idle_o,
	output logic host_tx_ready_o,
	output uart_byte_t uart_tx_o,
	output logic trigger_o,
	output logic [7:0] led_o,
	output logic user_programn_o
);

	// mode from the host register to the logger
	log_mode_e log_mode;

	reset_ctl u_reset_ctl (
		.clk(clk),
		.reset(reset),
		.btn_reboot_i(btn_reboot_i),
		.host_reboot_i(host_reboot_i),
		.sdram_reset_o(sdram_reset_o),
		.user_programn_o(user_programn_o)
	);

	sdram_arbiter u_sdram_arbiter (
		.clk(clk),
		.reset(reset),
		.spi_critical_i(spi_critical_i),
		.spi_refresh_inhibit_i(spi_refresh_inhibit_i),
		.spi_req_i(spi_req_i),
		.host_req_i(host_req_i),
		.sd_ack_level_i(sd_ack_level_i),
		.sd_idle_i(sd_idle_i),
		.uart_tx_ready_i(uart_tx_ready_i),
		.sd_req_o(sd_req_o),
		.sd_refresh_inhibit_o(sd_refresh_inhibit_o),
		.spi_ack_o(spi_ack_o),
		.host_ack_o(host_ack_o),
		.host_idle_o(host_idle_o),
		.host_tx_ready_o(host_tx_ready_o)
	);

	// led status shows the write enable actually sent to the sdram
	log_ctrl_regs u_log_ctrl_regs (
		.clk(clk),
		.reset(reset),
		.host_rx_i(host_rx_i),
		.spi_cs_n_i(spi_cs_n_i),
		.spi_output_enable_i(spi_output_enable_i),
		.spi_critical_i(spi_critical_i),
		.sd_we_i(sd_req_o.we),
		.spi_errors_i(spi_errors_i),
		.log_mode_o(log_mode),
		.led_o(led_o)
	);

	spi_log_serializer u_spi_log_serializer (
		.clk(clk),
		.reset(reset),
		.log_mode_i(log_mode),
		.spi_byte_i(spi_byte_i),
		.spi_log_i(spi_log_i),
		.host_tx_i(host_tx_i),
		.uart_tx_o(uart_tx_o),
		.trigger_o(trigger_o)
	);

endmodule

`default_nettype wire

//--- tb/tb_flash_emu.sv
// testbench for the flash emulator core
// reset, arbitration, all four log modes, trigger and leds
`timescale 1ns/100ps
`default_nettype none

module tb_flash_emu
	import flash_emu_pkg::*;
;

	logic clk;
	logic reset;
	spi_byte_t spi_byte_i;
	log_rec_t spi_log_i;
	logic spi_critical_i;
	logic spi_refresh_inhibit_i;
	logic spi_output_enable_i;
	logic spi_cs_n_i;
	logic [7:0] spi_errors_i;
	sd_req_t spi_req_i;
	sd_req_t host_req_i;
	logic sd_ack_level_i;
	logic sd_idle_i;
	uart_byte_t host_rx_i;
	uart_byte_t host_tx_i;
	logic uart_tx_ready_i;
	logic btn_reboot_i;
	logic host_reboot_i;
	sd_req_t sd_req_o;
	logic sd_refresh_inhibit_o;
	logic sdram_reset_o;
	logic spi_ack_o;
	logic host_ack_o;
	logic host_idle_o;
	logic host_tx_ready_o;
	uart_byte_t uart_tx_o;
	logic trigger_o;
	logic [7:0] led_o;
	logic user_programn_o;

	integer seed = 32'h4547_91a9;
	// serial bytes still expected with the oldest at the front
	logic [7:0] exp_q[$];
	// next spi byte index as the bus counts it
	logic [15:0] next_idx;
	log_mode_e mode;

	flash_emu_core uut (.*);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// reporting
	////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp)
			abort_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// reference model of the serial log
	////////////////////////////////////////////////////////////

	// byte list for one event with the top byte sent first
	function automatic int expected_bytes(input log_mode_e m, input logic is_rec,
		input logic [15:0] idx, input logic [7:0] mosi, input logic [7:0] miso,
		input logic [23:0] addr, input logic [7:0] len, output logic [63:0] bytes);
		bytes = '0;
		if (is_rec && m == LOG_COMPACT)
		begin
			bytes = {addr, len, 32'h0};
			return 4;
		end
		if (is_rec && m == LOG_VERBOSE)
		begin
			bytes = {"READ", addr, len};
			return 8;
		end
		if (!is_rec && m == LOG_MONITOR)
		begin
			bytes = {idx, mosi, miso, 32'h0};
			return 4;
		end
		// raw mode keeps the command byte and three after it
		if (!is_rec && m == LOG_BYTES && idx <= 16'd3)
		begin
			bytes = {mosi, 56'h0};
			return 1;
		end
		return 0;
	endfunction

	task automatic push_expected(input int n, input logic [63:0] bytes);
		for (int i = 0; i < n; i++)
			exp_q.push_back(bytes[63-8*i -: 8]);
	endtask

	// serial bytes are compared in order as they leave the DUT
	always @(negedge clk)
	begin
		if (!reset && uart_tx_o.strobe)
		begin
			if (exp_q.size() == 0)
				abort_run($sformatf("unexpected serial byte %h at %0t", uart_tx_o.data, $time));
			else
				check("uart_tx_o.data", uart_tx_o.data, exp_q.pop_front());
		end
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////

	task automatic quiet_cycle;
		@(negedge clk);
		spi_byte_i.strobe = 1'b0;
		spi_log_i.strobe = 1'b0;
		host_tx_i.strobe = 1'b0;
		host_rx_i.strobe = 1'b0;
	endtask

	task automatic wait_drain;
		int t;
		t = 0;
		while (exp_q.size() != 0)
		begin
			quiet_cycle();
			t++;
			if (t > 40)
				abort_run("serial output never produced the expected bytes");
		end
		quiet_cycle();
	endtask

	task automatic write_ctrl(input logic [7:0] data);
		@(negedge clk);
		host_rx_i = '{strobe: 1'b1, data: data};
		mode = log_mode_e'(data[1:0]);
		quiet_cycle();
	endtask

	task automatic send_spi(input logic cmd);
		logic [63:0] b;
		logic [15:0] idx;
		int n;
		@(negedge clk);
		spi_byte_i = '{strobe: 1'b1, cmd: cmd, mosi: $random(seed), miso: $random(seed)};
		idx = cmd ? 16'd0 : next_idx;
		next_idx = idx + 16'd1;
		n = expected_bytes(mode, 1'b0, idx, spi_byte_i.mosi, spi_byte_i.miso, '0, '0, b);
		push_expected(n, b);
		quiet_cycle();
	endtask

	task automatic send_rec(input logic [23:0] addr);
		logic [63:0] b;
		int n;
		@(negedge clk);
		spi_log_i = '{strobe: 1'b1, addr: addr, len: $random(seed)};
		n = expected_bytes(mode, 1'b1, '0, '0, '0, addr, spi_log_i.len, b);
		push_expected(n, b);
		quiet_cycle();
	endtask

	task automatic send_host;
		@(negedge clk);
		host_tx_i = '{strobe: 1'b1, data: $random(seed)};
		exp_q.push_back(host_tx_i.data);
		quiet_cycle();
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		int cnt;
		logic [63:0] r;
		logic ack_prev;
		logic we;
		reset = 1'b1;
		spi_byte_i = '0;
		spi_log_i = '0;
		spi_critical_i = 1'b0;
		spi_refresh_inhibit_i = 1'b0;
		spi_output_enable_i = 1'b0;
		spi_cs_n_i = 1'b1;
		spi_errors_i = '0;
		spi_req_i = '0;
		host_req_i = '0;
		sd_ack_level_i = 1'b0;
		sd_idle_i = 1'b0;
		host_rx_i = '0;
		host_tx_i = '0;
		uart_tx_ready_i = 1'b0;
		btn_reboot_i = 1'b0;
		host_reboot_i = 1'b0;
		next_idx = '0;
		mode = LOG_BYTES;
		repeat (5) @(negedge clk);
		reset = 1'b0;

		// sdram reset countdown
		cnt = 0;
		while (sdram_reset_o)
		begin
			@(negedge clk);
			cnt++;
			if (cnt > 1000)
				abort_run("sdram reset never released");
		end
		check("sdram_reset_o high cycles", cnt, SDRAM_RESET_CYCLES);

		// a held button pulls the reboot line low after exactly 128 edges
		btn_reboot_i = 1'b1;
		for (int i = 1; i <= 128; i++)
		begin
			@(negedge clk);
			check("user_programn_o", user_programn_o, i < 128);
		end
		btn_reboot_i = 1'b0;
		@(negedge clk);
		check("user_programn_o", user_programn_o, 1'b1);
		host_reboot_i = 1'b1;
		#1 check("user_programn_o", user_programn_o, 1'b0);
		@(negedge clk);
		host_reboot_i = 1'b0;

		// arbitration with random levels and requests
		ack_prev = 1'b0;
		for (int i = 0; i < 300; i++)
		begin
			@(negedge clk);
			spi_critical_i = $random(seed);
			spi_refresh_inhibit_i = $random(seed);
			sd_ack_level_i = $random(seed);
			sd_idle_i = $random(seed);
			uart_tx_ready_i = $random(seed);
			r = {$random(seed), $random(seed)};
			spi_req_i = r[50:0];
			r = {$random(seed), $random(seed)};
			host_req_i = r[50:0];
			#1;
			check("sd_req_o", sd_req_o, spi_critical_i ? spi_req_i : host_req_i);
			check("sd_refresh_inhibit_o", sd_refresh_inhibit_o,
				spi_critical_i & spi_refresh_inhibit_i);
			check("spi_ack_o", spi_ack_o, sd_ack_level_i & !ack_prev);
			check("host_ack_o", host_ack_o, sd_ack_level_i & !ack_prev & !spi_critical_i);
			check("host_idle_o", host_idle_o, sd_idle_i & !spi_critical_i);
			check("host_tx_ready_o", host_tx_ready_o, uart_tx_ready_i & !spi_critical_i);
			ack_prev = sd_ack_level_i;
		end
		@(negedge clk);
		spi_critical_i = 1'b0;
		sd_ack_level_i = 1'b0;

		// raw byte mode with random length transactions and host bytes between
		write_ctrl(8'h00);
		for (int t = 0; t < 12; t++)
		begin
			send_spi(1'b1);
			repeat ($random(seed) & 7) send_spi(1'b0);
			send_host();
			repeat ($random(seed) & 3) quiet_cycle();
		end
		wait_drain();

		// compact and verbose records away from the trigger address
		for (int m = 1; m <= 2; m++)
		begin
			write_ctrl(8'(m));
			for (int i = 0; i < 10; i++)
			begin
				send_rec(24'h800000 | 24'($random(seed)));
				wait_drain();
			end
			send_host();
			wait_drain();
		end

		// scope trigger from a record at the watched address
		check("trigger_o", trigger_o, 1'b0);
		send_rec(TRIGGER_ADDR);
		cnt = 0;
		while (!trigger_o)
		begin
			@(negedge clk);
			cnt++;
			if (cnt > 4)
				abort_run("trigger did not rise after the trigger record");
		end
		cnt = 0;
		while (trigger_o)
		begin
			@(negedge clk);
			cnt++;
			if (cnt > TRIGGER_HOLD + 2)
				abort_run("trigger stayed high too long");
		end
		wait_drain();

		// monitor mode where each byte gives index, mosi and miso
		write_ctrl(8'h03);
		for (int t = 0; t < 4; t++)
		begin
			send_spi(1'b1);
			wait_drain();
			repeat (1 + ($random(seed) & 3))
			begin
				send_spi(1'b0);
				wait_drain();
			end
		end

		// leds frozen on the host byte
		write_ctrl(8'h80 | 8'($random(seed)));
		@(negedge clk);
		check("led_o", led_o, host_rx_i.data);

		// live led status
		write_ctrl(8'h00);
		for (int i = 0; i < 40; i++)
		begin
			@(negedge clk);
			spi_errors_i = $random(seed);
			spi_cs_n_i = $random(seed);
			spi_output_enable_i = $random(seed);
			spi_critical_i = $random(seed);
			r = {$random(seed), $random(seed)};
			spi_req_i = r[50:0];
			r = {$random(seed), $random(seed)};
			host_req_i = r[50:0];
			we = spi_critical_i ? spi_req_i.we : host_req_i.we;
			#1 check("led_o", led_o, {spi_errors_i[7:4], we, spi_critical_i,
				spi_output_enable_i, !spi_cs_n_i});
		end

		wait_drain();
		if (exp_q.size() == 0)
			$display("ALL TESTS PASSED");
		else
			abort_run("expected serial bytes were never sent");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
src/flash_emu_pkg.sv
src/reset_ctl.sv
src/sdram_arbiter.sv
src/log_ctrl_regs.sv
src/spi_log_serializer.sv
src/flash_emu_core.sv
tb/tb_flash_emu.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the flash emulator testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f verilog.f --top-module tb_flash_emu -o vsim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/vsim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
